// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_stu_cntl
FILELIST := all.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh test/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(BUILD)

// ==== all.f ====
+incdir+hw
+incdir+test
hw/stu_pkg.sv
hw/stu_rx_fifo.sv
hw/stu_packet_router.sv
hw/stu_cntl.sv
test/tb_stu_cntl.sv

// ==== hw/stu_cntl.sv ====
// top of the upstream receive controller, one lane into the FIFO and out through the router
`default_nettype none
`timescale 1ns/1ps

module stu_cntl (
  input  wire logic               clk,
  input  wire logic               arst_n,
  // upstream lane
  input  wire logic               up_valid,
  input  wire stu_pkg::up_beat_t  up_beat,
  output logic                    up_ready,
  // return data processor
  output logic                    rdp_valid,
  output stu_pkg::down_beat_t     rdp_beat,
  input  wire logic               rdp_ready,
  // return control processor
  output logic                    rcp_valid,
  output stu_pkg::down_beat_t     rcp_beat,
  input  wire logic               rcp_ready,
  output logic                    protocol_error
);

  //------------------------------
  // fifo to router
  //------------------------------
  logic               pipe_valid;
  stu_pkg::up_beat_t  pipe_beat;
  logic               pipe_read;

  stu_rx_fifo stu_rx_fifo_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (up_valid),
    .in_beat    (up_beat),
    .in_ready   (up_ready),
    .pipe_valid (pipe_valid),
    .pipe_beat  (pipe_beat),
    .pipe_read  (pipe_read)
  );

  stu_packet_router stu_packet_router_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .pipe_valid     (pipe_valid),
    .pipe_beat      (pipe_beat),
    .pipe_read      (pipe_read),
    .rdp_valid      (rdp_valid),
    .rdp_beat       (rdp_beat),
    .rdp_ready      (rdp_ready),
    .rcp_valid      (rcp_valid),
    .rcp_beat       (rcp_beat),
    .rcp_ready      (rcp_ready),
    .protocol_error (protocol_error)
  );

endmodule

`default_nettype wire

// ==== hw/stu_packet_router.sv ====
// packet framing check and routing of beats to the return data and control processor ports
`default_nettype none
`timescale 1ns/1ps

`include "stu_params.svh"

module stu_packet_router (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               pipe_valid,
  input  wire stu_pkg::up_beat_t  pipe_beat,
  output logic                    pipe_read,
  output logic                    rdp_valid,
  output stu_pkg::down_beat_t     rdp_beat,
  input  wire logic               rdp_ready,
  output logic                    rcp_valid,
  output stu_pkg::down_beat_t     rcp_beat,
  input  wire logic               rcp_ready,
  output logic                    protocol_error
);

  stu_pkg::rx_state_e   state;
  stu_pkg::rx_state_e   state_next;
  stu_pkg::pkt_type_e   route;       // port of the current packet
  logic                 marker_ok;
  logic                 bad_marker;
  logic                 rdp_issue;
  logic                 rcp_issue;
  stu_pkg::down_beat_t  out_beat;

  //------------------------------
  // framing check
  //------------------------------

  always_comb
  begin
    route     = pipe_beat.ptype;     // only trusted on the first beat
    marker_ok = 1'b0;
    case (state)
      stu_pkg::IDLE:
      begin
        marker_ok = (pipe_beat.cntl == stu_pkg::SOM) ||
                    (pipe_beat.cntl == stu_pkg::SOM_EOM);
      end
      stu_pkg::IN_CONTROL:
      begin
        route     = stu_pkg::CONTROL;
        marker_ok = (pipe_beat.cntl == stu_pkg::MOM) ||
                    (pipe_beat.cntl == stu_pkg::EOM);
      end
      stu_pkg::IN_DATA:
      begin
        route     = stu_pkg::DATA;
        marker_ok = (pipe_beat.cntl == stu_pkg::MOM) ||
                    (pipe_beat.cntl == stu_pkg::EOM);
      end
      default:
      begin
        marker_ok = 1'b0;  // error, nothing passes
      end
    endcase
  end

  // bad marker trips the error whatever the ports say
  assign bad_marker = pipe_valid && !marker_ok && (state != stu_pkg::ERROR);

  assign rcp_issue = pipe_valid && marker_ok && (route == stu_pkg::CONTROL) && rcp_ready;
  assign rdp_issue = pipe_valid && marker_ok && (route == stu_pkg::DATA) && rdp_ready;
  assign pipe_read = rcp_issue || rdp_issue;

  //------------------------------
  // next state
  //------------------------------

  always_comb
  begin
    state_next = state;
    if (bad_marker)
      state_next = stu_pkg::ERROR;
    else if (pipe_read)
    begin
      case (pipe_beat.cntl)
        stu_pkg::SOM:
        begin
          if (route == stu_pkg::DATA)
            state_next = stu_pkg::IN_DATA;
          else
            state_next = stu_pkg::IN_CONTROL;
        end
        stu_pkg::MOM:     state_next = state;
        default:          state_next = stu_pkg::IDLE;  // EOM or SOM_EOM closes it
      endcase
    end
  end

  // same fields on both ports, tag cut from oob
  always_comb
  begin
    out_beat.cntl = pipe_beat.cntl;
    out_beat.tag  = pipe_beat.oob[`STU_TAG_W-1:0];
    out_beat.data = pipe_beat.data;
  end

  //------------------------------
  // registered outputs
  //------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state          <= stu_pkg::IDLE;
      rdp_valid      <= 1'b0;
      rcp_valid      <= 1'b0;
      protocol_error <= 1'b0;
    end
    else
    begin
      state          <= state_next;
      rdp_valid      <= rdp_issue;   // one-cycle pulse
      rcp_valid      <= rcp_issue;
      protocol_error <= (state_next == stu_pkg::ERROR);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rdp_issue)
      rdp_beat <= out_beat;
    if (rcp_issue)
      rcp_beat <= out_beat;
  end

  a_one_port : assert property (
    @(posedge clk) disable iff (!arst_n) !(rdp_valid && rcp_valid))
    else $error("both processor ports valid together");

  // error is sticky until reset
  a_error_latched : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == stu_pkg::ERROR) |=> (state == stu_pkg::ERROR))
    else $error("router left the error state");

endmodule

`default_nettype wire

// ==== hw/stu_params.svh ====
// width, depth and threshold macros for the receive controller, include wherever a size is needed

`ifndef STU_PARAMS_SVH
`define STU_PARAMS_SVH

//------------------------------
// upstream beat fields
//------------------------------

// payload of every beat
`define STU_DATA_W 64

// out-of-band word sent alongside the data
`define STU_OOB_W 32

// tag sits in the low bits of the oob word
`define STU_TAG_W 8

//------------------------------
// receive FIFO sizing
//------------------------------

`define STU_FIFO_DEPTH 16

// almost-full level, leaves slack for the input register
// and for the beat sent while ready is still falling
`define STU_FIFO_THRESHOLD 12

`endif

// ==== hw/stu_pkg.sv ====
// shared types of the receive controller, referenced by scoped name from the RTL and testbench
`default_nettype none

`include "stu_params.svh"

package stu_pkg;

  //------------------------------
  // framing marker on every beat
  //------------------------------
  typedef enum logic [1:0] {
    SOM_EOM = 2'b00,  // single-beat packet
    SOM     = 2'b01,
    MOM     = 2'b10,
    EOM     = 2'b11
  } cntl_e;

  // packet class, picks the processor port
  typedef enum logic {
    CONTROL = 1'b0,
    DATA    = 1'b1
  } pkt_type_e;

  // router state
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    IN_CONTROL = 2'd1,
    IN_DATA    = 2'd2,
    ERROR      = 2'd3   // latched until reset
  } rx_state_e;

  //------------------------------
  // beat formats
  //------------------------------

  // upstream beat, 99 bits
  typedef struct packed {
    cntl_e                   cntl;
    pkt_type_e               ptype;
    logic [`STU_DATA_W-1:0]  data;
    logic [`STU_OOB_W-1:0]   oob;
  } up_beat_t;

  // beat toward a processor, 74 bits
  typedef struct packed {
    cntl_e                   cntl;
    logic [`STU_TAG_W-1:0]   tag;
    logic [`STU_DATA_W-1:0]  data;
  } down_beat_t;

endpackage

`default_nettype wire

// ==== hw/stu_rx_fifo.sv ====
// upstream input register, receive FIFO and prefetch pipe, feeds the packet router one beat at a time
`default_nettype none
`timescale 1ns/1ps

`include "stu_params.svh"

module stu_rx_fifo #(
  parameter int DEPTH = `STU_FIFO_DEPTH
) (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               in_valid,
  input  wire stu_pkg::up_beat_t  in_beat,
  output logic                    in_ready,
  output logic                    pipe_valid,
  output stu_pkg::up_beat_t       pipe_beat,
  input  wire logic               pipe_read
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic               in_reg_valid;  // input register
  stu_pkg::up_beat_t  in_reg_beat;

  stu_pkg::up_beat_t  mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               wr_en;
  logic               rd_en;

  logic               pf_valid;      // prefetch stage
  stu_pkg::up_beat_t  pf_beat;
  logic               pf_read;

  // circular increment, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  //------------------------------
  // stage handshakes
  //------------------------------

  assign wr_en   = in_reg_valid;                          // no ready check here
  assign rd_en   = (count != '0) && (!pf_valid || pf_read); // keep prefetch charged
  assign pf_read = pf_valid && (!pipe_valid || pipe_read);

  //------------------------------
  // control state
  //------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      in_reg_valid <= 1'b0;
      in_ready     <= 1'b0;
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      pf_valid     <= 1'b0;
      pipe_valid   <= 1'b0;
    end
    else
    begin
      in_reg_valid <= in_valid;
      in_ready     <= (count < CNT_W'(`STU_FIFO_THRESHOLD));  // lags count by a cycle

      if (wr_en)
        wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en)
        rd_ptr <= ptr_inc(rd_ptr);

      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // a stage fills when loaded, empties when drained and not refilled
      if (rd_en)
        pf_valid <= 1'b1;
      else if (pf_read)
        pf_valid <= 1'b0;

      if (pf_read)
        pipe_valid <= 1'b1;
      else if (pipe_read)
        pipe_valid <= 1'b0;
    end
  end

  //------------------------------
  // payload path
  //------------------------------

  always_ff @(posedge clk)
  begin
    if (in_valid)
      in_reg_beat <= in_beat;
    if (wr_en)
      mem[wr_ptr] <= in_reg_beat;
    if (rd_en)
      pf_beat <= mem[rd_ptr];
    if (pf_read)
      pipe_beat <= pf_beat;
  end

  // upstream must have honoured in_ready, otherwise a beat is dropped here
  a_no_write_full : assert property (
    @(posedge clk) disable iff (!arst_n) wr_en |-> (count != CNT_W'(DEPTH)))
    else $error("receive FIFO written while full");

  // router only pulls a beat that the pipe stage holds
  a_no_read_empty : assert property (
    @(posedge clk) disable iff (!arst_n) pipe_read |-> pipe_valid)
    else $error("pipe stage read while empty");

endmodule

`default_nettype wire

// ==== test/tb_stu_ref.svh ====
// reference model and packet generators, included inside the receive controller testbench
`ifndef TB_STU_REF_SVH
`define TB_STU_REF_SVH

int                   seed = 32'h3ed50184;  // one seed for every random draw
stu_pkg::down_beat_t  rdp_q[$];             // expected beats, one queue per port
stu_pkg::down_beat_t  rcp_q[$];
bit                   sending;

// expected port and beat for one upstream beat of a packet
function automatic stu_pkg::down_beat_t stu_expect(input stu_pkg::up_beat_t beat,
                                                   input stu_pkg::pkt_type_e pkt_type,
                                                   output bit to_rdp);
  stu_pkg::down_beat_t want;
  to_rdp    = (pkt_type == stu_pkg::DATA);  // whole packet follows its first beat
  want.cntl = beat.cntl;
  want.tag  = beat.oob[`STU_TAG_W-1:0];
  want.data = beat.data;
  return want;
endfunction

// present one beat once up_ready allows it
task automatic send_beat(input stu_pkg::up_beat_t beat, input stu_pkg::pkt_type_e pkt_type,
                         input bit expect_out);
  stu_pkg::down_beat_t want;
  bit                  to_rdp;
  int                  waited;
  waited = 0;
  @(negedge clk);
  while (!up_ready && waited < 200)
  begin
    up_valid = 1'b0;
    waited++;
    @(negedge clk);
  end
  if (!up_ready)
  begin
    $display("%s: up_ready stayed low, beat was never sent", test_name);
    errors++;
  end
  else
  begin
    if (expect_out)
    begin
      want = stu_expect(beat, pkt_type, to_rdp);
      if (to_rdp)
        rdp_q.push_back(want);
      else
        rcp_q.push_back(want);
    end
    up_valid = 1'b1;
    up_beat  = beat;
  end
endtask

// well-framed packet of n beats with random payload
task automatic send_packet(input stu_pkg::pkt_type_e pkt_type, input int n,
                           input bit expect_out);
  stu_pkg::up_beat_t beat;
  sending = 1'b1;
  for (int i = 0; i < n; i++)
  begin
    if (n == 1)
      beat.cntl = stu_pkg::SOM_EOM;
    else if (i == 0)
      beat.cntl = stu_pkg::SOM;
    else if (i == n - 1)
      beat.cntl = stu_pkg::EOM;
    else
      beat.cntl = stu_pkg::MOM;
    beat.ptype = pkt_type;
    beat.data  = {$random(seed), $random(seed)};
    beat.oob   = $random(seed);
    send_beat(beat, pkt_type, expect_out);
  end
  @(negedge clk);
  up_valid = 1'b0;
  sending  = 1'b0;
endtask

task automatic send_random_packet();
  logic [31:0] rnd;
  rnd = $random(seed);
  send_packet(rnd[0] ? stu_pkg::DATA : stu_pkg::CONTROL, 1 + int'(rnd[7:4]) % 6, 1'b1);
endtask

`endif

// ==== test/tb_stu_cntl.sv ====
// top-level testbench that streams packets into the receive controller and checks both ports
`default_nettype none
`timescale 1ns/1ps

`include "stu_params.svh"

module tb_stu_cntl;

  logic                 clk;
  logic                 arst_n;
  logic                 up_valid;
  stu_pkg::up_beat_t    up_beat;
  logic                 up_ready;
  logic                 rdp_valid;
  stu_pkg::down_beat_t  rdp_beat;
  logic                 rdp_ready;
  logic                 rcp_valid;
  stu_pkg::down_beat_t  rcp_beat;
  logic                 rcp_ready;
  logic                 protocol_error;

  string  test_name = "reset";
  int     errors;      // stimulus thread
  int     cmp_errors;  // compare process
  int     err_mark;
  int     checks;
  int     rdp_count;
  int     rcp_count;

  `include "tb_stu_ref.svh"

  stu_cntl stu_cntl_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .up_valid       (up_valid),
    .up_beat        (up_beat),
    .up_ready       (up_ready),
    .rdp_valid      (rdp_valid),
    .rdp_beat       (rdp_beat),
    .rdp_ready      (rdp_ready),
    .rcp_valid      (rcp_valid),
    .rcp_beat       (rcp_beat),
    .rcp_ready      (rcp_ready),
    .protocol_error (protocol_error)
  );

  always #20 clk = ~clk;  // 40 ns period

  //------------------------------
  // compare at the falling edge where outputs are stable
  //------------------------------
  always @(negedge clk)
  begin
    stu_pkg::down_beat_t want;
    if (arst_n)
    begin
      assert (!(rdp_valid && rcp_valid))
      else
      begin
        $display("%s: both processor ports were valid in one cycle", test_name);
        cmp_errors++;
      end
      if (rdp_valid)
      begin
        rdp_count++;
        if (rdp_q.size() == 0)
        begin
          $display("%s: a data port beat arrived with none expected", test_name);
          cmp_errors++;
        end
        else
        begin
          want = rdp_q.pop_front();
          checks++;
          assert (rdp_beat == want)
          else
          begin
            $display("[FAIL] %s rdp expected %h actual %h", test_name, want, rdp_beat);
            cmp_errors++;
          end
        end
      end
      if (rcp_valid)
      begin
        rcp_count++;
        if (rcp_q.size() == 0)
        begin
          $display("%s: a control port beat arrived with none expected", test_name);
          cmp_errors++;
        end
        else
        begin
          want = rcp_q.pop_front();
          checks++;
          assert (rcp_beat == want)
          else
          begin
            $display("[FAIL] %s rcp expected %h actual %h", test_name, want, rcp_beat);
            cmp_errors++;
          end
        end
      end
    end
  end

  task automatic apply_reset();
    arst_n   = 1'b0;
    up_valid = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
  endtask

  // all expected beats delivered and the sender idle
  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while ((rdp_q.size() != 0 || rcp_q.size() != 0 || sending) && waited < limit)
    begin
      @(negedge clk);
      waited++;
    end
    assert (rdp_q.size() == 0 && rcp_q.size() == 0 && !sending)
    else
    begin
      $display("%s: timed out with %0d data and %0d control beats undelivered",
               test_name, rdp_q.size(), rcp_q.size());
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors + cmp_errors;
  endtask

  task automatic end_test();
    $display("%s finished with %0d errors", test_name, errors + cmp_errors - err_mark);
  endtask

  initial
  begin
    int                 waited;
    int                 rdp_before;
    int                 rcp_before;
    logic [31:0]        rnd;
    bit                 stop_toggle;
    stu_pkg::up_beat_t  bad;
    clk       = 1'b0;
    arst_n    = 1'b0;
    up_valid  = 1'b0;
    up_beat   = '0;
    rdp_ready = 1'b1;
    rcp_ready = 1'b1;
    apply_reset();

    start_test("single_beat");
    send_packet(stu_pkg::CONTROL, 1, 1'b1);
    send_packet(stu_pkg::DATA, 1, 1'b1);
    wait_drain(200);
    end_test();

    start_test("random_packets");
    for (int k = 0; k < 20; k++)
      send_random_packet();
    wait_drain(1000);
    end_test();

    start_test("backpressure");
    rdp_ready  = 1'b0;
    rdp_before = rdp_count;
    sending    = 1'b1;
    fork
      send_packet(stu_pkg::DATA, 24, 1'b1);
    join_none
    waited = 0;
    while (up_ready && waited < 100)
    begin
      @(negedge clk);
      waited++;
    end
    repeat (10) @(negedge clk);
    assert (!up_ready && rdp_count == rdp_before)
    else
    begin
      $display("%s: up_ready did not drop or a data beat slipped through", test_name);
      errors++;
    end
    rdp_ready = 1'b1;
    wait_drain(1000);
    end_test();

    start_test("ready_toggle");
    stop_toggle = 1'b0;
    fork
      begin
        for (int k = 0; k < 12; k++)
          send_random_packet();
        stop_toggle = 1'b1;
      end
      begin
        waited = 0;
        while (!stop_toggle && waited < 5000)
        begin
          @(negedge clk);
          rnd       = $random(seed);
          rdp_ready = rnd[0];
          rcp_ready = rnd[1];
          waited++;
        end
        assert (stop_toggle)
        else
        begin
          $display("%s: packets were still being sent when ready toggling timed out",
                   test_name);
          errors++;
        end
      end
    join
    rdp_ready = 1'b1;
    rcp_ready = 1'b1;
    wait_drain(2000);
    end_test();

    start_test("framing_error");
    bad       = '0;
    bad.cntl  = stu_pkg::MOM;
    bad.ptype = stu_pkg::CONTROL;
    send_beat(bad, stu_pkg::CONTROL, 1'b0);
    @(negedge clk);
    up_valid = 1'b0;
    waited   = 0;
    while (!protocol_error && waited < 50)
    begin
      @(negedge clk);
      waited++;
    end
    rdp_before = rdp_count;
    rcp_before = rcp_count;
    send_packet(stu_pkg::DATA, 2, 1'b0);
    repeat (20) @(negedge clk);
    assert (protocol_error && rdp_count == rdp_before && rcp_count == rcp_before)
    else
    begin
      $display("%s: protocol_error not held or a beat left after the error", test_name);
      errors++;
    end
    end_test();

    start_test("reset_recovery");
    apply_reset();
    waited = 0;
    while (!up_ready && waited < 20)
    begin
      @(negedge clk);
      waited++;
    end
    assert (up_ready && !protocol_error)
    else
    begin
      $display("%s: up_ready did not return high after reset", test_name);
      errors++;
    end
    for (int k = 0; k < 4; k++)
      send_random_packet();
    wait_drain(500);
    end_test();

    $display("%0d beats checked, %0d errors", checks, errors + cmp_errors);
    if (errors + cmp_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
